//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing -j 0
TOP       := ipv4_tx_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard logic/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Exit status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/clk_gen.sv
`default_nettype none
`timescale 1ns/100ps

module clk_gen (
  output logic clk,
  output logic fsm_rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    fsm_rst = 1'b1;
    repeat (10) @(posedge clk);
    fsm_rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/ipv4_tx_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipv4_tx_macros.svh"

module ipv4_tx_tb;

  import ipv4_tx_pkg::*;

  localparam int WAIT_LIMIT = 2000;

  logic        clk;
  logic        fsm_rst;
  mac_addr_t   dev_mac;
  logic        tx_rdy;
  ipv4_addr_t  src_ip;
  ipv4_addr_t  dst_ip;
  byte_t       proto;
  byte_t       ttl;
  byte_t       qos;
  logic [15:0] id;
  logic        df;
  logic        mf;
  logic [12:0] frag_off;
  length_t     pld_len;
  logic        mac_known;
  mac_addr_t   dst_mac;
  logic        tx_ack;
  logic        tx_done;
  logic        pld_wr;
  byte_t       pld_wdat;
  logic        arp_wr;
  ipv4_addr_t  arp_wr_ip;
  mac_addr_t   arp_wr_mac;
  logic        mac_rdy;
  logic        mac_req;
  logic        mac_done;
  mac_addr_t   mac_src;
  mac_addr_t   mac_dst;
  logic [15:0] mac_ethertype;
  length_t     mac_length;
  logic        mac_val;
  logic        mac_sof;
  logic        mac_eof;
  byte_t       mac_dat;

  string       test_name;
  int          err_count;
  int          test_count;
  int          fail_count;
  int          errs_at_start;
  byte_t       pld_q [$];
  byte_t       exp_q [$];

  clk_gen u_clk_gen (
    .clk     (clk),
    .fsm_rst (fsm_rst)
  );

  ipv4_tx_top u_ipv4_tx_top (.*);

  // ##################################################
  // Reporting
  // ##################################################

  task automatic finish_run();
    $display("%0d tests, %0d failed, %0d errors", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      err_count++;
      $display("** Error %s: %s expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic time_out(input string what);
    err_count++;
    $display("Test %s stopped, no %s within %0d cycles", test_name, what, WAIT_LIMIT);
    finish_run();
  endtask

  task automatic begin_test(input string name);
    test_name     = name;
    errs_at_start = err_count;
    test_count++;
  endtask

  task automatic end_test();
    if (err_count == errs_at_start) begin
      $display("Test %s: ok", test_name);
    end else begin
      fail_count++;
      $display("Test %s: %0d errors", test_name, err_count - errs_at_start);
    end
  endtask

  // ##################################################
  // Reference model and stimulus
  // ##################################################

  function automatic mac_addr_t rand_mac();
    return {16'($urandom), $urandom};
  endfunction

  // Inverted one's complement sum of the ten header words
  function automatic logic [15:0] header_checksum(input byte_t h [`IPV4_HDR_LEN]);
    logic [31:0] acc;
    acc = '0;
    for (int w = 0; w < `IPV4_HDR_LEN / 2; w++) begin
      acc = acc + 32'({h[2*w], h[2*w+1]});
    end
    while (acc[31:16] != 16'd0) acc = 32'(acc[15:0]) + 32'(acc[31:16]);
    return ~acc[15:0];
  endfunction

  task automatic write_payload(input int len);
    byte_t b;
    pld_q.delete();
    for (int i = 0; i < len; i++) begin
      b = byte_t'($urandom);
      pld_q.push_back(b);
      @(posedge clk);
      pld_wr   <= 1'b1;
      pld_wdat <= b;
    end
    @(posedge clk);
    pld_wr <= 1'b0;
  endtask

  task automatic arp_fill(input ipv4_addr_t ip, input mac_addr_t mac);
    @(posedge clk);
    arp_wr     <= 1'b1;
    arp_wr_ip  <= ip;
    arp_wr_mac <= mac;
    @(posedge clk);
    arp_wr <= 1'b0;
  endtask

  // Random fields, expected bytes, then the tx_rdy/tx_ack handshake
  task automatic request(input logic known, input mac_addr_t dmac, input ipv4_addr_t dip,
                         input int len);
    byte_t       h [`IPV4_HDR_LEN];
    ipv4_addr_t  sip;
    byte_t       f_proto;
    byte_t       f_ttl;
    byte_t       f_qos;
    logic [15:0] f_id;
    logic        f_df;
    logic        f_mf;
    logic [12:0] f_frag;
    length_t     tot;
    logic [15:0] cks;
    int          n;
    sip     = $urandom;
    f_proto = byte_t'($urandom);
    f_ttl   = byte_t'($urandom);
    f_qos   = byte_t'($urandom);
    f_id    = 16'($urandom);
    f_df    = 1'($urandom);
    f_mf    = 1'($urandom);
    f_frag  = 13'($urandom);
    tot     = length_t'(len + `IPV4_HDR_LEN);
    h[0]    = 8'h45;
    h[1]    = f_qos;
    h[2]    = tot[15:8];
    h[3]    = tot[7:0];
    h[4]    = f_id[15:8];
    h[5]    = f_id[7:0];
    h[6]    = {1'b0, f_df, f_mf, f_frag[12:8]};
    h[7]    = f_frag[7:0];
    h[8]    = f_ttl;
    h[9]    = f_proto;
    h[10]   = 8'h00;
    h[11]   = 8'h00;
    for (int k = 0; k < 4; k++) begin
      h[12+k] = sip[31-8*k -: 8];
      h[16+k] = dip[31-8*k -: 8];
    end
    cks   = header_checksum(h);
    h[10] = cks[15:8];
    h[11] = cks[7:0];
    exp_q.delete();
    foreach (h[k]) exp_q.push_back(h[k]);
    foreach (pld_q[k]) exp_q.push_back(pld_q[k]);

    @(posedge clk);
    src_ip    <= sip;
    dst_ip    <= dip;
    proto     <= f_proto;
    ttl       <= f_ttl;
    qos       <= f_qos;
    id        <= f_id;
    df        <= f_df;
    mf        <= f_mf;
    frag_off  <= f_frag;
    pld_len   <= length_t'(len);
    mac_known <= known;
    dst_mac   <= dmac;
    tx_rdy    <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) time_out("tx_ack");
    end while (!tx_ack);
    tx_rdy <= 1'b0;
    check("tx_ack latency", 64'd2, 64'(n));
    @(posedge clk);
    check("tx_ack pulse", 64'd0, 64'(tx_ack));
  endtask

  // Offer, optional back-pressure, stream and done on the MAC side
  task automatic receive_frame(input mac_addr_t exp_dst, input int hold);
    int n;
    int cnt;
    n = 0;
    do begin
      @(posedge clk);
      check("mac_val before grant", 64'd0, 64'(mac_val));
      n++;
      if (n > WAIT_LIMIT) time_out("mac_rdy");
    end while (!mac_rdy);
    check("mac_src", 64'(dev_mac), 64'(mac_src));
    check("mac_dst", 64'(exp_dst), 64'(mac_dst));
    check("mac_ethertype", 64'h0800, 64'(mac_ethertype));
    check("mac_length", 64'(exp_q.size()), 64'(mac_length));
    for (int k = 0; k < hold; k++) begin
      @(posedge clk);
      check("mac_rdy held", 64'd1, 64'(mac_rdy));
      check("mac_val held", 64'd0, 64'(mac_val));
      check("mac_dst held", 64'(exp_dst), 64'(mac_dst));
    end
    mac_req <= 1'b1;
    @(posedge clk);
    mac_req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) time_out("first byte");
    end while (!mac_val);
    check("first byte latency", 64'd2, 64'(n));
    cnt = 0;
    while (mac_val) begin
      if (cnt < exp_q.size()) begin
        check($sformatf("byte %0d", cnt), 64'(exp_q[cnt]), 64'(mac_dat));
      end
      check("mac_sof", 64'(cnt == 0), 64'(mac_sof));
      check("mac_eof", 64'(cnt == exp_q.size() - 1), 64'(mac_eof));
      cnt++;
      if (cnt > WAIT_LIMIT) time_out("end of frame");
      @(posedge clk);
    end
    check("byte count", 64'(exp_q.size()), 64'(cnt));
    mac_done <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      mac_done <= 1'b0;
      n++;
      if (n > WAIT_LIMIT) time_out("tx_done");
    end while (!tx_done);
    check("tx_done latency", 64'd2, 64'(n));
    @(posedge clk);
  endtask

  // ##################################################
  // Tests
  // ##################################################

  task automatic reset_state();
    begin_test("reset_state");
    @(posedge clk);
    check("tx_ack", 64'd0, 64'(tx_ack));
    check("tx_done", 64'd0, 64'(tx_done));
    check("mac_rdy", 64'd0, 64'(mac_rdy));
    check("mac_val", 64'd0, 64'(mac_val));
    check("mac_sof", 64'd0, 64'(mac_sof));
    check("mac_eof", 64'd0, 64'(mac_eof));
    check("arp_req", 64'd0, 64'(u_ipv4_tx_top.arp_req));
    check("rd_en", 64'd0, 64'(u_ipv4_tx_top.rd_en));
    end_test();
  endtask

  task automatic known_mac_frame(input string name, input int hold);
    mac_addr_t dmac;
    int        len;
    begin_test(name);
    dmac = rand_mac();
    len  = int'($urandom_range(64, 1));
    write_payload(len);
    request(1'b1, dmac, {8'hc0, 24'($urandom)}, len);
    receive_frame(dmac, hold);
    end_test();
  endtask

  task automatic arp_hit();
    ipv4_addr_t ip;
    mac_addr_t  mac;
    int         len;
    begin_test("arp_hit");
    ip  = {8'h0a, 24'($urandom)};
    mac = rand_mac();
    arp_fill({8'h0a, 24'($urandom)}, rand_mac());
    arp_fill(ip, mac);
    arp_fill({8'h0a, 24'($urandom)}, rand_mac());
    len = int'($urandom_range(64, 1));
    write_payload(len);
    // dst_mac input is ignored on the lookup path
    request(1'b0, rand_mac(), ip, len);
    receive_frame(mac, 0);
    end_test();
  endtask

  task automatic arp_miss();
    int n;
    begin_test("arp_miss");
    write_payload(int'($urandom_range(16, 1)));
    request(1'b0, rand_mac(), {8'hac, 24'($urandom)}, pld_q.size());
    n = 0;
    do begin
      @(posedge clk);
      check("mac_rdy", 64'd0, 64'(mac_rdy));
      check("mac_val", 64'd0, 64'(mac_val));
      n++;
      if (n > WAIT_LIMIT) time_out("tx_done after the ARP miss");
    end while (!tx_done);
    @(posedge clk);
    end_test();
  endtask

  task automatic back_to_back();
    ipv4_addr_t ip;
    mac_addr_t  old_mac;
    mac_addr_t  new_mac;
    mac_addr_t  dmac;
    int         len;
    begin_test("back_to_back");
    ip      = {8'h0a, 24'($urandom)};
    old_mac = rand_mac();
    new_mac = rand_mac();
    arp_fill(ip, old_mac);
    for (int p = 0; p < 4; p++) begin
      len = int'($urandom_range(200, 1));
      write_payload(len);
      if (p[0]) begin
        request(1'b0, rand_mac(), ip, len);
        receive_frame((p == 1) ? old_mac : new_mac, 0);
      end else begin
        dmac = rand_mac();
        request(1'b1, dmac, {8'hc0, 24'($urandom)}, len);
        receive_frame(dmac, 0);
      end
      // Same IP with a new MAC
      if (p == 1) arp_fill(ip, new_mac);
    end
    end_test();
  endtask

  initial begin
    int n;
    void'($urandom(32'h8b74_12d3));
    err_count  = 0;
    test_count = 0;
    fail_count = 0;
    test_name  = "startup";
    dev_mac    = 48'h02_00_5e_10_20_30;
    tx_rdy     = 1'b0;
    src_ip     = '0;
    dst_ip     = '0;
    proto      = '0;
    ttl        = '0;
    qos        = '0;
    id         = '0;
    df         = 1'b0;
    mf         = 1'b0;
    frag_off   = '0;
    pld_len    = '0;
    mac_known  = 1'b0;
    dst_mac    = '0;
    pld_wr     = 1'b0;
    pld_wdat   = '0;
    arp_wr     = 1'b0;
    arp_wr_ip  = '0;
    arp_wr_mac = '0;
    mac_req    = 1'b0;
    mac_done   = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) time_out("release of reset");
    end while (fsm_rst);

    reset_state();
    known_mac_frame("known_mac", 0);
    arp_hit();
    arp_miss();
    known_mac_frame("back_pressure", int'($urandom_range(40, 5)));
    back_to_back();
    finish_run();
  end

endmodule

`default_nettype wire

//--- logic/arp_cache.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipv4_tx_macros.svh"

module arp_cache (
  input  logic                     clk,
  input  logic                     fsm_rst,
  input  logic                     arp_wr,
  input  ipv4_tx_pkg::ipv4_addr_t  arp_wr_ip,
  input  ipv4_tx_pkg::mac_addr_t   arp_wr_mac,
  input  logic                     arp_req,
  input  ipv4_tx_pkg::ipv4_addr_t  arp_ip,
  output logic                     arp_val,
  output logic                     arp_err,
  output ipv4_tx_pkg::mac_addr_t   arp_mac
);

  import ipv4_tx_pkg::*;

  localparam int IDX_W = $clog2(`ARP_ENTRIES);

  logic [`ARP_ENTRIES-1:0] ent_val;
  ipv4_addr_t              ent_ip  [`ARP_ENTRIES];
  mac_addr_t               ent_mac [`ARP_ENTRIES];
  logic [IDX_W-1:0]        fill_ptr;
  logic                    wr_hit;
  logic [IDX_W-1:0]        wr_idx;
  logic [IDX_W-1:0]        wr_sel;
  logic                    rd_hit;
  mac_addr_t               rd_mac;

  // Parallel compare for both the fill and the lookup port
  always_comb begin
    wr_hit = 1'b0;
    wr_idx = '0;
    rd_hit = 1'b0;
    rd_mac = '0;
    for (int k = 0; k < `ARP_ENTRIES; k++) begin
      if (ent_val[k] && (ent_ip[k] == arp_wr_ip)) begin
        wr_hit = 1'b1;
        wr_idx = IDX_W'(k);
      end
      if (ent_val[k] && (ent_ip[k] == arp_ip)) begin
        rd_hit = 1'b1;
        rd_mac = ent_mac[k];
      end
    end
  end

  // Known IP is updated in place
  assign wr_sel = wr_hit ? wr_idx : fill_ptr;

  always_ff @(posedge clk) begin
    if (arp_wr) begin
      ent_ip[wr_sel]  <= arp_wr_ip;
      ent_mac[wr_sel] <= arp_wr_mac;
    end
    if (arp_req) arp_mac <= rd_mac;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      ent_val  <= '0;
      fill_ptr <= '0;
      arp_val  <= 1'b0;
      arp_err  <= 1'b0;
    end else begin
      if (arp_wr) begin
        ent_val[wr_sel] <= 1'b1;
        if (!wr_hit) begin
          fill_ptr <= (fill_ptr == IDX_W'(`ARP_ENTRIES - 1)) ? '0 : fill_ptr + 1'b1;
        end
      end
      arp_val <= arp_req && rd_hit;
      arp_err <= arp_req && !rd_hit;
    end
  end

endmodule

`default_nettype wire

//--- logic/checksum_tree.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipv4_tx_macros.svh"

module checksum_tree (
  input  logic                                    clk,
  input  logic [(2**`IPV4_CKS_LEVELS)-1:0][15:0]  words,
  output ipv4_tx_pkg::cks_sum_t                   sum
);

  localparam int N_WORDS = 2**`IPV4_CKS_LEVELS;

  // One register stage per level, one extra bit per level
  genvar lv;
  genvar i;
  generate
    for (lv = 0; lv < `IPV4_CKS_LEVELS; lv++) begin : g_lvl
      localparam int W = 17 + lv;
      localparam int N = N_WORDS >> (lv + 1);

      logic [W-1:0] node [N];

      if (lv == 0) begin : g_first
        // Pairs of input words
        for (i = 0; i < N; i++) begin : g_add
          always_ff @(posedge clk) begin
            node[i] <= W'(words[2*i]) + W'(words[2*i+1]);
          end
        end
      end else begin : g_next
        // Pairs of the level before
        for (i = 0; i < N; i++) begin : g_add
          always_ff @(posedge clk) begin
            node[i] <= W'(g_lvl[lv-1].node[2*i]) + W'(g_lvl[lv-1].node[2*i+1]);
          end
        end
      end
    end
  endgenerate

  assign sum = g_lvl[`IPV4_CKS_LEVELS-1].node[0];

endmodule

`default_nettype wire

//--- logic/ipv4_tx.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipv4_tx_macros.svh"

module ipv4_tx (
  input  logic                                    clk,
  input  logic                                    fsm_rst,
  input  ipv4_tx_pkg::mac_addr_t                  dev_mac,
  input  logic                                    tx_rdy,
  input  ipv4_tx_pkg::ipv4_addr_t                 src_ip,
  input  ipv4_tx_pkg::ipv4_addr_t                 dst_ip,
  input  ipv4_tx_pkg::byte_t                      proto,
  input  ipv4_tx_pkg::byte_t                      ttl,
  input  ipv4_tx_pkg::byte_t                      qos,
  input  logic [15:0]                             id,
  input  logic                                    df,
  input  logic                                    mf,
  input  logic [12:0]                             frag_off,
  input  ipv4_tx_pkg::length_t                    pld_len,
  input  logic                                    mac_known,
  input  ipv4_tx_pkg::mac_addr_t                  dst_mac,
  output logic                                    tx_ack,
  output logic                                    tx_done,
  output logic                                    arp_req,
  output ipv4_tx_pkg::ipv4_addr_t                 arp_ip,
  input  logic                                    arp_val,
  input  logic                                    arp_err,
  input  ipv4_tx_pkg::mac_addr_t                  arp_mac,
  output logic [(2**`IPV4_CKS_LEVELS)-1:0][15:0]  cks_words,
  input  ipv4_tx_pkg::cks_sum_t                   cks_sum,
  output logic                                    rd_en,
  input  ipv4_tx_pkg::byte_t                      rd_dat,
  output logic                                    mac_rdy,
  input  logic                                    mac_req,
  input  logic                                    mac_done,
  output ipv4_tx_pkg::mac_addr_t                  mac_src,
  output ipv4_tx_pkg::mac_addr_t                  mac_dst,
  output logic [15:0]                             mac_ethertype,
  output ipv4_tx_pkg::length_t                    mac_length,
  output logic                                    mac_val,
  output logic                                    mac_sof,
  output logic                                    mac_eof,
  output ipv4_tx_pkg::byte_t                      mac_dat
);

  import ipv4_tx_pkg::*;

  localparam int      CNT_W    = $clog2(`IPV4_CKS_LEVELS + 1);
  localparam int      PAD_W    = 16 * (2**`IPV4_CKS_LEVELS) - 8 * `IPV4_HDR_LEN;
  localparam length_t RD_START = length_t'(`IPV4_HDR_LEN - 4);
  localparam length_t HDR_LAST = length_t'(`IPV4_HDR_LEN - 1);

  tx_state_t                   state;
  byte_t [`IPV4_HDR_LEN-1:0]   hdr;
  length_t                     req_len;
  length_t                     byte_cnt;
  logic                        last_byte;
  logic                        hdr_done;
  logic [CNT_W-1:0]            cks_cnt;
  logic                        cks_ready;
  logic                        cks_loaded;
  logic [16:0]                 fold1;
  logic [15:0]                 fold2;
  logic [15:0]                 cks;
  logic                        restart;

  // Done pulse restarts the engine
  assign restart = fsm_rst || tx_done;

  assign req_len       = pld_len + length_t'(`IPV4_HDR_LEN);
  assign last_byte     = (byte_cnt == mac_length - 16'd1);
  assign mac_ethertype = ethertype_ipv4;

  // Header words into the adder tree, upper words zero
  assign cks_words = {{PAD_W{1'b0}}, hdr};

  // Fold carries twice, second fold cannot overflow
  assign fold1     = {1'b0, cks_sum[15:0]} + 17'(cks_sum[19:16]);
  assign fold2     = fold1[15:0] + 16'(fold1[16]);
  assign cks       = ~fold2;
  assign cks_ready = (cks_cnt == CNT_W'(`IPV4_CKS_LEVELS));

  // ##################################################
  // Header, metadata and stream data
  // ##################################################

  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (tx_rdy) begin
          hdr[19]    <= {4'd4, 4'd5};
          hdr[18]    <= qos;
          hdr[17:16] <= req_len;
          hdr[15:14] <= id;
          hdr[13]    <= {1'b0, df, mf, frag_off[12:8]};
          hdr[12]    <= frag_off[7:0];
          hdr[11]    <= ttl;
          hdr[10]    <= proto;
          hdr[9:8]   <= '0;
          hdr[7:4]   <= src_ip;
          hdr[3:0]   <= dst_ip;
          mac_src    <= dev_mac;
          mac_dst    <= dst_mac;
          mac_length <= req_len;
          arp_ip     <= dst_ip;
        end
      end
      arp_wait: begin
        if (arp_val) mac_dst <= arp_mac;
      end
      prep: begin
        if (cks_ready && !cks_loaded) hdr[9:8] <= cks;
      end
      active: begin
        // Header goes out first byte first
        mac_dat                  <= hdr_done ? rd_dat : hdr[`IPV4_HDR_LEN-1];
        hdr[`IPV4_HDR_LEN-1:1]   <= hdr[`IPV4_HDR_LEN-2:0];
      end
      default: ;
    endcase
  end

  // ##################################################
  // FSM and strobes
  // ##################################################

  always_ff @(posedge clk) begin
    if (restart) begin
      state      <= idle;
      tx_ack     <= 1'b0;
      tx_done    <= 1'b0;
      arp_req    <= 1'b0;
      mac_rdy    <= 1'b0;
      mac_val    <= 1'b0;
      mac_sof    <= 1'b0;
      mac_eof    <= 1'b0;
      rd_en      <= 1'b0;
      byte_cnt   <= '0;
      hdr_done   <= 1'b0;
      cks_cnt    <= '0;
      cks_loaded <= 1'b0;
    end else begin
      tx_ack  <= 1'b0;
      tx_done <= (arp_err && (state == arp_wait)) ||
                 (mac_done && ((state == active) || (state == wait_done)));
      case (state)
        idle: begin
          if (tx_rdy) begin
            tx_ack <= 1'b1;
            if (mac_known) begin
              state <= prep;
            end else begin
              state   <= arp_wait;
              arp_req <= 1'b1;
            end
          end
        end
        arp_wait: begin
          if (arp_val) begin
            arp_req <= 1'b0;
            state   <= prep;
          end else if (arp_err) begin
            // Miss, no frame
            arp_req <= 1'b0;
            state   <= wait_done;
          end
        end
        prep: begin
          if (!cks_ready) cks_cnt <= cks_cnt + 1'b1;
          else cks_loaded <= 1'b1;
          if (cks_loaded) mac_rdy <= 1'b1;
          if (mac_rdy && mac_req) begin
            mac_rdy <= 1'b0;
            state   <= active;
          end
        end
        active: begin
          mac_val  <= 1'b1;
          mac_sof  <= (byte_cnt == '0);
          mac_eof  <= last_byte;
          byte_cnt <= byte_cnt + 16'd1;
          // Buffer needs 4 cycles to present its first byte
          if (byte_cnt == RD_START) rd_en <= 1'b1;
          if (byte_cnt == HDR_LAST) hdr_done <= 1'b1;
          if (last_byte) begin
            rd_en <= 1'b0;
            state <= wait_done;
          end
        end
        wait_done: begin
          mac_val <= 1'b0;
          mac_sof <= 1'b0;
          mac_eof <= 1'b0;
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/ipv4_tx_macros.svh
`ifndef IPV4_TX_MACROS_SVH
`define IPV4_TX_MACROS_SVH

// ##################################################
// Sizes of the IPv4 transmit path
// ##################################################

// Header length in bytes, no options
`define IPV4_HDR_LEN 20

// Adder tree depth, takes up to 2**levels words
`define IPV4_CKS_LEVELS 4

// ARP cache size
`define ARP_ENTRIES 8

// Payload buffer depth in bytes
`define PLD_DEPTH 256

`endif

//--- logic/ipv4_tx_pkg.sv
`default_nettype none

package ipv4_tx_pkg;

  // ##################################################
  // Field types
  // ##################################################

  typedef logic [31:0] ipv4_addr_t;

  typedef logic [47:0] mac_addr_t;

  // Payload or total length in bytes
  typedef logic [15:0] length_t;

  typedef logic [7:0] byte_t;

  // Header sum with carries kept
  typedef logic [19:0] cks_sum_t;

  // ##################################################
  // Engine FSM
  // ##################################################

  typedef enum logic [2:0] {
    idle,
    arp_wait,
    prep,
    active,
    wait_done
  } tx_state_t;

  // Ethertype for IPv4 frames
  localparam logic [15:0] ethertype_ipv4 = 16'h0800;

endpackage

`default_nettype wire

//--- logic/ipv4_tx_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipv4_tx_macros.svh"

module ipv4_tx_top (
  input  logic                     clk,
  input  logic                     fsm_rst,
  input  ipv4_tx_pkg::mac_addr_t   dev_mac,
  input  logic                     tx_rdy,
  input  ipv4_tx_pkg::ipv4_addr_t  src_ip,
  input  ipv4_tx_pkg::ipv4_addr_t  dst_ip,
  input  ipv4_tx_pkg::byte_t       proto,
  input  ipv4_tx_pkg::byte_t       ttl,
  input  ipv4_tx_pkg::byte_t       qos,
  input  logic [15:0]              id,
  input  logic                     df,
  input  logic                     mf,
  input  logic [12:0]              frag_off,
  input  ipv4_tx_pkg::length_t     pld_len,
  input  logic                     mac_known,
  input  ipv4_tx_pkg::mac_addr_t   dst_mac,
  output logic                     tx_ack,
  output logic                     tx_done,
  input  logic                     pld_wr,
  input  ipv4_tx_pkg::byte_t       pld_wdat,
  input  logic                     arp_wr,
  input  ipv4_tx_pkg::ipv4_addr_t  arp_wr_ip,
  input  ipv4_tx_pkg::mac_addr_t   arp_wr_mac,
  output logic                     mac_rdy,
  input  logic                     mac_req,
  input  logic                     mac_done,
  output ipv4_tx_pkg::mac_addr_t   mac_src,
  output ipv4_tx_pkg::mac_addr_t   mac_dst,
  output logic [15:0]              mac_ethertype,
  output ipv4_tx_pkg::length_t     mac_length,
  output logic                     mac_val,
  output logic                     mac_sof,
  output logic                     mac_eof,
  output ipv4_tx_pkg::byte_t       mac_dat
);

  import ipv4_tx_pkg::*;

  logic                                    arp_req;
  ipv4_addr_t                              arp_ip;
  logic                                    arp_val;
  logic                                    arp_err;
  mac_addr_t                               arp_mac;
  logic [(2**`IPV4_CKS_LEVELS)-1:0][15:0]  cks_words;
  cks_sum_t                                cks_sum;
  logic                                    rd_en;
  byte_t                                   rd_dat;

  ipv4_tx u_ipv4_tx (
    .clk           (clk),
    .fsm_rst       (fsm_rst),
    .dev_mac       (dev_mac),
    .tx_rdy        (tx_rdy),
    .src_ip        (src_ip),
    .dst_ip        (dst_ip),
    .proto         (proto),
    .ttl           (ttl),
    .qos           (qos),
    .id            (id),
    .df            (df),
    .mf            (mf),
    .frag_off      (frag_off),
    .pld_len       (pld_len),
    .mac_known     (mac_known),
    .dst_mac       (dst_mac),
    .tx_ack        (tx_ack),
    .tx_done       (tx_done),
    .arp_req       (arp_req),
    .arp_ip        (arp_ip),
    .arp_val       (arp_val),
    .arp_err       (arp_err),
    .arp_mac       (arp_mac),
    .cks_words     (cks_words),
    .cks_sum       (cks_sum),
    .rd_en         (rd_en),
    .rd_dat        (rd_dat),
    .mac_rdy       (mac_rdy),
    .mac_req       (mac_req),
    .mac_done      (mac_done),
    .mac_src       (mac_src),
    .mac_dst       (mac_dst),
    .mac_ethertype (mac_ethertype),
    .mac_length    (mac_length),
    .mac_val       (mac_val),
    .mac_sof       (mac_sof),
    .mac_eof       (mac_eof),
    .mac_dat       (mac_dat)
  );

  checksum_tree u_checksum_tree (
    .clk   (clk),
    .words (cks_words),
    .sum   (cks_sum)
  );

  arp_cache u_arp_cache (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .arp_wr     (arp_wr),
    .arp_wr_ip  (arp_wr_ip),
    .arp_wr_mac (arp_wr_mac),
    .arp_req    (arp_req),
    .arp_ip     (arp_ip),
    .arp_val    (arp_val),
    .arp_err    (arp_err),
    .arp_mac    (arp_mac)
  );

  // Buffer rewinds at the end of every request
  payload_buffer u_payload_buffer (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .pld_wr   (pld_wr),
    .pld_wdat (pld_wdat),
    .rd_en    (rd_en),
    .pkt_done (tx_done),
    .rd_dat   (rd_dat)
  );

endmodule

`default_nettype wire

//--- logic/payload_buffer.sv
`default_nettype none
`timescale 1ns/100ps

`include "ipv4_tx_macros.svh"

module payload_buffer (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                pld_wr,
  input  ipv4_tx_pkg::byte_t  pld_wdat,
  input  logic                rd_en,
  input  logic                pkt_done,
  output ipv4_tx_pkg::byte_t  rd_dat
);

  import ipv4_tx_pkg::*;

  localparam int AW = $clog2(`PLD_DEPTH);

  byte_t         mem [`PLD_DEPTH];
  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;
  logic          wr_full;
  logic [AW-1:0] rd_addr;
  logic          addr_ok;
  byte_t         ram_q;
  logic          ram_ok;

  assign wr_full = wr_ptr[AW];

  always_ff @(posedge clk) begin
    if (pld_wr && !wr_full) mem[wr_ptr[AW-1:0]] <= pld_wdat;
  end

  // ##################################################
  // Read pipeline: address, RAM, output register
  // ##################################################

  always_ff @(posedge clk) begin
    rd_addr <= rd_ptr[AW-1:0];
    ram_q   <= mem[rd_addr];
    // Zero past the written count
    rd_dat  <= ram_ok ? ram_q : '0;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst || pkt_done) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      addr_ok <= 1'b0;
      ram_ok  <= 1'b0;
    end else begin
      if (pld_wr && !wr_full) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en && !rd_ptr[AW]) rd_ptr <= rd_ptr + 1'b1;
      addr_ok <= rd_en && (rd_ptr < wr_ptr);
      ram_ok  <= addr_ok;
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
logic/ipv4_tx_pkg.sv
logic/checksum_tree.sv
logic/arp_cache.sv
logic/payload_buffer.sv
logic/ipv4_tx.sv
logic/ipv4_tx_top.sv
bench/clk_gen.sv
bench/ipv4_tx_tb.sv
